// ==== list.f ====
hw/lawnPkg.sv
hw/plantGrid.sv
hw/zombieHorde.sv
hw/lawnRenderer.sv
hw/lawnTop.sv
tb/tbClock.sv
tb/lawnTop_asserts.sv
tb/lawnTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the lawn game testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module lawnTb -f list.f
# The status of the last command is the result: grep fails when the pass line is missing
./obj_dir/VlawnTb | tee /dev/stderr | grep -qx "No errors"

// ==== tb/lawnTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module lawnTb;

	localparam int clockPeriod = 20;
	localparam int tickDiv = 4;
	localparam int killHits = 5;
	localparam int eatTicks = 8;
	localparam int walnutEatTicks = 20;

	localparam int lanes = lawnPkg::lanes;
	localparam int columns = lawnPkg::columns;
	localparam int menuBottom = int'(lawnPkg::menuBottom);
	localparam int lawnTop = int'(lawnPkg::lawnTop);
	localparam int rowHeight = int'(lawnPkg::rowHeight);
	localparam int lawnLeft = int'(lawnPkg::lawnLeft);
	localparam int columnWidth = int'(lawnPkg::columnWidth);
	localparam int menuBoxWidth = int'(lawnPkg::menuBoxWidth);
	localparam int startX = int'(lawnPkg::zombieStartX);
	localparam int endOfLawn = int'(lawnPkg::endOfLawn);
	localparam int staggerGap = int'(lawnPkg::staggerGap);
	localparam int halfBody = int'(lawnPkg::halfBodyWidth);
	localparam int bodyHeight = int'(lawnPkg::bodyHeight);
	localparam int outline = int'(lawnPkg::outlineWidth);

	// Cycle budgets per test step that the watchdog adds up
	localparam int resetBudget = 50;
	localparam int noPlantBudget = 3000;
	localparam int waitBudget = 1200;
	localparam int placeBudget = 25;
	localparam int finishBudget = 2000;
	localparam int randomBudget = 3200;
	localparam int pixelBudget = 1500;
	localparam int totalCycles = resetBudget + noPlantBudget + 3 * waitBudget +
		8 * placeBudget + finishBudget + randomBudget + pixelBudget;
	localparam longint watchdogNs = longint'(2 * totalCycles + 1000) * clockPeriod;

	// Button vector order is select, left, right, up, down
	localparam logic [4:0] noButton = 5'b00000;
	localparam logic [4:0] downPress = 5'b00001;
	localparam logic [4:0] upPress = 5'b00010;
	localparam logic [4:0] rightPress = 5'b00100;
	localparam logic [4:0] leftPress = 5'b01000;
	localparam logic [4:0] selectPress = 5'b10000;

	logic clk;
	logic rstN;
	logic bright;
	lawnPkg::coordT hCount;
	lawnPkg::coordT vCount;
	logic upButton;
	logic downButton;
	logic leftButton;
	logic rightButton;
	logic selectButton;
	lawnPkg::rgbT rgb;
	logic [2:0] zombiesKilled;
	lawnPkg::gameStateE gameState;

	// Reference model state as it stands after each rising edge
	lawnPkg::menuStateE mMenu;
	int mMenuCol;
	int mChosen;
	int mRow;
	int mCol;
	int mCell[lanes][columns];
	int mDiv;
	int mX[lanes];
	bit mAlive[lanes];
	int mHits[lanes];
	int mEat[lanes];
	bit mPulse[lanes];
	int mKilled;
	lawnPkg::gameStateE mState;

	string currentTest;
	int pixelMode;
	int errorCount;
	int checkCount;
	int testCount;
	int failedTests;
	int testStartErrors;

	tbClock #(.period(clockPeriod)) u_clock (.clk(clk));

	lawnTop
	#(
		.tickDiv(tickDiv),
		.killHits(killHits),
		.eatTicks(eatTicks),
		.walnutEatTicks(walnutEatTicks)
	)
	u_dut
	(
		.clk(clk),
		.rstN(rstN),
		.bright(bright),
		.hCount(hCount),
		.vCount(vCount),
		.upButton(upButton),
		.downButton(downButton),
		.leftButton(leftButton),
		.rightButton(rightButton),
		.selectButton(selectButton),
		.rgb(rgb),
		.zombiesKilled(zombiesKilled),
		.gameState(gameState)
	);

	function automatic int cellLeftOf(input int col);
		return lawnLeft + col * columnWidth;
	endfunction

	function automatic int rowTopOf(input int row);
		return lawnTop + row * rowHeight;
	endfunction

	function automatic int clampInt(input int value, input int low, input int high);
		if (value < low)
			return low;
		if (value > high)
			return high;
		return value;
	endfunction

	// Lane 1 leads and the others follow their own leader
	function automatic bit gateOpen(input int lane);
		case (lane)
			0: return mX[1] <= startX - 2 * staggerGap;
			1: return 1'b1;
			2, 3: return mX[0] <= startX - staggerGap;
			default: return mX[3] <= startX - staggerGap;
		endcase
	endfunction

	task automatic checkValue(input string what, input int expected, input int actual);
		checkCount++;
		if (expected != actual)
		begin
			errorCount++;
			$display("mismatch in %s: %s expected 0x%0h actual 0x%0h", currentTest, what,
				expected, actual);
		end
	endtask

	task automatic modelReset();
		mMenu = lawnPkg::pickKind;
		mMenuCol = 0;
		mChosen = 0;
		mRow = 0;
		mCol = 0;
		mDiv = 0;
		mKilled = 0;
		mState = lawnPkg::playing;
		for (int r = 0; r < lanes; r++)
		begin
			mX[r] = startX;
			mAlive[r] = 1'b1;
			mHits[r] = 0;
			mEat[r] = 0;
			mPulse[r] = 1'b0;
			for (int c = 0; c < columns; c++)
				mCell[r][c] = 0;
		end
	endtask

	task automatic modelAdvance(input logic [4:0] buttons);
		int frontCol[lanes];
		bit frontValid[lanes];
		int frontKind[lanes];
		bit pea[lanes];
		int nextX[lanes];
		bit nextAlive[lanes];
		bit nextPulse[lanes];
		int nextKilled;
		int limit;
		bit tick;
		bit atEnd;
		for (int r = 0; r < lanes; r++)
		begin
			frontCol[r] = 0;
			frontValid[r] = 1'b0;
			frontKind[r] = 0;
			pea[r] = 1'b0;
			for (int c = 0; c < columns; c++)
			begin
				if (mCell[r][c] != 0)
				begin
					frontCol[r] = c;
					frontValid[r] = 1'b1;
					frontKind[r] = mCell[r][c];
				end
				if (mCell[r][c] == int'(lawnPkg::peashooter))
					pea[r] = 1'b1;
			end
			nextX[r] = mX[r];
			nextAlive[r] = mAlive[r];
			nextPulse[r] = 1'b0;
		end
		nextKilled = mKilled;
		tick = (mDiv == tickDiv - 1);
		mDiv = tick ? 0 : mDiv + 1;
		if (tick && mState == lawnPkg::playing)
		begin
			for (int z = 0; z < lanes; z++)
			begin
				if (mAlive[z])
				begin
					if (frontValid[z] && mX[z] == cellLeftOf(frontCol[z]) + columnWidth / 2)
					begin
						limit = (frontKind[z] == int'(lawnPkg::walnut)) ? walnutEatTicks :
							eatTicks;
						mEat[z]++;
						if (mEat[z] == limit)
						begin
							nextPulse[z] = 1'b1;
							mEat[z] = 0;
						end
					end
					else
					begin
						mEat[z] = 0;
						if (gateOpen(z))
							nextX[z] = mX[z] - 1;
					end
					if (pea[z] && mX[z] < startX)
					begin
						mHits[z]++;
						if (mHits[z] == killHits)
						begin
							nextAlive[z] = 1'b0;
							nextKilled++;
						end
					end
				end
			end
			atEnd = 1'b0;
			for (int z = 0; z < lanes; z++)
				if (nextAlive[z] && nextX[z] == endOfLawn)
					atEnd = 1'b1;
			if (atEnd)
				mState = lawnPkg::lost;
			else if (nextKilled == lanes)
				mState = lawnPkg::won;
		end
		if (buttons[4])
		begin
			if (mMenu == lawnPkg::pickKind)
			begin
				mChosen = mMenuCol + 1;
				mMenu = lawnPkg::pickCell;
			end
			else if (mCell[mRow][mCol] == 0)
			begin
				mCell[mRow][mCol] = mChosen;
				mMenu = lawnPkg::pickKind;
			end
		end
		else if (buttons[3])
		begin
			if (mMenu == lawnPkg::pickKind && mMenuCol > 0)
				mMenuCol--;
			else if (mMenu == lawnPkg::pickCell && mCol > 0)
				mCol--;
		end
		else if (buttons[2])
		begin
			if (mMenu == lawnPkg::pickKind && mMenuCol < 2)
				mMenuCol++;
			else if (mMenu == lawnPkg::pickCell && mCol < columns - 1)
				mCol++;
		end
		else if (buttons[1])
		begin
			if (mMenu == lawnPkg::pickCell && mRow > 0)
				mRow--;
		end
		else if (buttons[0])
		begin
			if (mMenu == lawnPkg::pickCell && mRow < lanes - 1)
				mRow++;
		end
		// An eat pulse from the previous cycle clears the lane's front plant
		// A select on the same edge still sees that cell as occupied
		for (int r = 0; r < lanes; r++)
			if (mPulse[r])
				mCell[r][frontCol[r]] = 0;
		mX = nextX;
		mAlive = nextAlive;
		mPulse = nextPulse;
		mKilled = nextKilled;
	endtask

	function automatic int expectedColour(input bit lit, input int h, input int v);
		int left;
		int right;
		int top;
		int bottom;
		int row;
		int col;
		int dx;
		int dy;
		int kind;
		if (!lit)
			return int'(lawnPkg::black);
		if (mMenu == lawnPkg::pickKind)
		begin
			left = mMenuCol * menuBoxWidth;
			right = left + menuBoxWidth - 1;
			top = 0;
			bottom = menuBottom;
		end
		else
		begin
			left = cellLeftOf(mCol);
			right = left + columnWidth - 1;
			top = rowTopOf(mRow);
			bottom = top + rowHeight - 1;
		end
		if (h >= left && h <= right && v >= top && v <= bottom &&
			(h - left < outline || right - h < outline || v - top < outline ||
			bottom - v < outline))
			return int'(lawnPkg::red);
		for (int r = 0; r < lanes; r++)
			if (mAlive[r] && h >= mX[r] - halfBody && h <= mX[r] + halfBody &&
				v >= rowTopOf(r) && v < rowTopOf(r) + bodyHeight)
				return int'(lawnPkg::zombieSkin);
		row = -1;
		col = -1;
		if (h >= lawnLeft && v >= lawnTop && (h - lawnLeft) / columnWidth < columns &&
			(v - lawnTop) / rowHeight < lanes)
		begin
			col = (h - lawnLeft) / columnWidth;
			row = (v - lawnTop) / rowHeight;
			kind = mCell[row][col];
			dx = h - cellLeftOf(col);
			dy = v - rowTopOf(row);
			// Markers fill the middle half of the cell in both directions
			if (kind != 0 && dx >= columnWidth / 4 && dx < columnWidth - columnWidth / 4 &&
				dy >= rowHeight / 4 && dy < rowHeight - rowHeight / 4)
			begin
				if (kind == int'(lawnPkg::peashooter))
					return int'(lawnPkg::plantPea);
				else if (kind == int'(lawnPkg::sunflower))
					return int'(lawnPkg::plantSun);
				else
					return int'(lawnPkg::plantNut);
			end
		end
		if (v <= menuBottom)
			return int'(lawnPkg::grey);
		if (row >= 0 && (row + col) % 2 == 1)
			return int'(lawnPkg::darkGreen);
		return int'(lawnPkg::green);
	endfunction

	// Mode 0 is dark, mode 1 mixes bright, mode 2 is bright and aims at the interesting spots
	task automatic choosePixel();
		int pick;
		int lane;
		int h;
		int v;
		int left;
		int top;
		pick = (pixelMode == 2) ? int'($urandom % 4) : 0;
		h = int'($urandom % 800);
		v = int'($urandom % 525);
		lane = int'($urandom % lanes);
		if (pick == 1)
		begin
			h = mX[lane] - 12 + int'($urandom % 25);
			v = rowTopOf(lane) - 4 + int'($urandom % 60);
		end
		else if (pick == 2)
		begin
			left = (mMenu == lawnPkg::pickKind) ? mMenuCol * menuBoxWidth : cellLeftOf(mCol);
			top = (mMenu == lawnPkg::pickKind) ? 0 : rowTopOf(mRow);
			h = left - 3 + int'($urandom % (columnWidth + 6));
			v = top - 3 + int'($urandom % (rowHeight + 6));
		end
		else if (pick == 3)
		begin
			h = cellLeftOf(int'($urandom % columns)) + int'($urandom % columnWidth);
			v = rowTopOf(lane) + int'($urandom % rowHeight);
		end
		hCount = lawnPkg::coordT'(clampInt(h, 0, 799));
		vCount = lawnPkg::coordT'(clampInt(v, 0, 524));
		if (pixelMode == 0)
			bright = 1'b0;
		else if (pixelMode == 2)
			bright = 1'b1;
		else
			bright = 1'($urandom % 2);
	endtask

	// Starts and ends on a falling edge and compares outputs once the rising edge has settled
	task automatic stepCycle(input logic [4:0] buttons);
		{selectButton, leftButton, rightButton, upButton, downButton} = buttons;
		choosePixel();
		@(posedge clk);
		modelAdvance(buttons);
		@(negedge clk);
		checkValue("gameState", int'(mState), int'(gameState));
		checkValue("zombiesKilled", mKilled, int'(zombiesKilled));
		checkValue("rgb", expectedColour(bright, int'(hCount), int'(vCount)), int'(rgb));
	endtask

	task automatic applyReset();
		rstN = 1'b0;
		{selectButton, leftButton, rightButton, upButton, downButton} = noButton;
		repeat (2) @(negedge clk);
		rstN = 1'b1;
		modelReset();
	endtask

	function automatic logic [4:0] randomButtons(input int spread);
		int r;
		r = int'($urandom % spread);
		if (r < 5)
			return 5'(1 << r);
		if (r == 5)
			return 5'($urandom % 32);
		return noButton;
	endfunction

	// Assumes the menu FSM sits in pickKind
	task automatic placePlant(input int kind, input int row, input int col);
		repeat (2) stepCycle(leftPress);
		repeat (kind - 1) stepCycle(rightPress);
		stepCycle(selectPress);
		repeat (lanes - 1) stepCycle(upPress);
		repeat (row) stepCycle(downPress);
		repeat (columns - 1) stepCycle(leftPress);
		repeat (col) stepCycle(rightPress);
		stepCycle(selectPress);
	endtask

	task automatic waitForLeader(input int lane, input int limit);
		int n;
		n = 0;
		while (mX[lane] > limit && n < waitBudget)
		begin
			stepCycle(noButton);
			n++;
		end
		if (mX[lane] > limit)
		begin
			errorCount++;
			$display("test %s: zombie in lane %0d never reached x %0d", currentTest, lane, limit);
		end
	endtask

	task automatic runUntilOver(input int bound);
		int n;
		n = 0;
		while (gameState == lawnPkg::playing && n < bound)
		begin
			stepCycle(noButton);
			n++;
		end
		if (gameState == lawnPkg::playing)
		begin
			errorCount++;
			$display("test %s: game still running after %0d cycles", currentTest, bound);
		end
	endtask

	task automatic beginTest(input string name);
		currentTest = name;
		testStartErrors = errorCount;
	endtask

	task automatic endTest();
		testCount++;
		if (errorCount != testStartErrors)
			failedTests++;
		$display("test %s finished with %0d failures", currentTest,
			errorCount - testStartErrors);
	endtask

	initial
	begin
		rstN = 1'b0;
		bright = 1'b0;
		hCount = '0;
		vCount = '0;
		{selectButton, leftButton, rightButton, upButton, downButton} = noButton;
		errorCount = 0;
		checkCount = 0;
		testCount = 0;
		failedTests = 0;
		pixelMode = 0;
		void'($urandom(32));
		modelReset();
		@(negedge clk);

		beginTest("afterReset");
		applyReset();
		pixelMode = 0;
		repeat (20) stepCycle(noButton);
		checkValue("gameState", int'(lawnPkg::playing), int'(gameState));
		checkValue("zombiesKilled", 0, int'(zombiesKilled));
		endTest();

		beginTest("noPlants");
		applyReset();
		pixelMode = 1;
		runUntilOver(noPlantBudget);
		checkValue("final gameState", int'(lawnPkg::lost), int'(gameState));
		checkValue("final zombiesKilled", 0, int'(zombiesKilled));
		endTest();

		// Each lane gets its peashooter only once the lanes it leads have started
		beginTest("peaEveryLane");
		applyReset();
		pixelMode = 1;
		waitForLeader(1, startX - 2 * staggerGap);
		placePlant(int'(lawnPkg::peashooter), 1, 4);
		waitForLeader(0, startX - staggerGap);
		placePlant(int'(lawnPkg::peashooter), 0, 4);
		waitForLeader(3, startX - staggerGap);
		placePlant(int'(lawnPkg::peashooter), 3, 4);
		placePlant(int'(lawnPkg::peashooter), 2, 4);
		placePlant(int'(lawnPkg::peashooter), 4, 4);
		runUntilOver(finishBudget);
		checkValue("final gameState", int'(lawnPkg::won), int'(gameState));
		checkValue("final zombiesKilled", lanes, int'(zombiesKilled));
		endTest();

		beginTest("randomPlay");
		applyReset();
		pixelMode = 1;
		repeat (randomBudget) stepCycle(randomButtons(10));
		checkValue("final gameState", int'(mState), int'(gameState));
		checkValue("final zombiesKilled", mKilled, int'(zombiesKilled));
		endTest();

		beginTest("pixels");
		applyReset();
		pixelMode = 2;
		placePlant(int'(lawnPkg::sunflower), 2, 1);
		placePlant(int'(lawnPkg::walnut), 3, 2);
		placePlant(int'(lawnPkg::peashooter), 0, 4);
		repeat (pixelBudget) stepCycle(randomButtons(12));
		endTest();

		$display("summary: %0d tests, %0d failed, %0d checks, %0d errors", testCount,
			failedTests, checkCount, errorCount);
		if (errorCount == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	initial
	begin
		#(watchdogNs);
		$display("watchdog: run did not finish within %0d ns", watchdogNs);
		$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/lawnTop_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none

module lawnTopAsserts
(
	input wire clk,
	input wire rstN,
	input wire bright,
	input wire lawnPkg::rgbT rgb,
	input wire [2:0] zombiesKilled,
	input wire lawnPkg::gameStateE gameState
);

	// Once the game is decided the outcome holds until reset
	wonSticky: assert property (@(posedge clk) disable iff (!rstN)
		gameState == lawnPkg::won |=> gameState == lawnPkg::won)
		else $error("game left the won state without a reset");

	lostSticky: assert property (@(posedge clk) disable iff (!rstN)
		gameState == lawnPkg::lost |=> gameState == lawnPkg::lost)
		else $error("game left the lost state without a reset");

	killLimit: assert property (@(posedge clk) disable iff (!rstN)
		zombiesKilled <= 3'd5)
		else $error("kill count went above five");

	// Blanking forces black no matter what the lawn holds
	darkIsBlack: assert property (@(posedge clk) !bright |-> rgb == lawnPkg::black)
		else $error("pixel not black while bright is low");

endmodule

bind lawnTop lawnTopAsserts u_asserts
(
	.clk(clk),
	.rstN(rstN),
	.bright(bright),
	.rgb(rgb),
	.zombiesKilled(zombiesKilled),
	.gameState(gameState)
);

`default_nettype wire

// ==== tb/tbClock.sv ====
`timescale 1ns/1ns
`default_nettype none

module tbClock
#(
	parameter int period = 20
)
(
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

endmodule

`default_nettype wire

// ==== hw/lawnTop.sv ====
`timescale 1ns/1ns
`default_nettype none

module lawnTop
#(
	parameter int tickDiv = 1000000,
	parameter int killHits = 5,
	parameter int eatTicks = 200,
	parameter int walnutEatTicks = 600
)
(
	input wire clk,
	input wire rstN,
	input wire bright,
	input wire lawnPkg::coordT hCount,
	input wire lawnPkg::coordT vCount,
	input wire upButton,
	input wire downButton,
	input wire leftButton,
	input wire rightButton,
	input wire selectButton,
	output lawnPkg::rgbT rgb,
	output logic [2:0] zombiesKilled,
	output lawnPkg::gameStateE gameState
);

	lawnPkg::menuStateE menuState;
	logic [1:0] menuCol;
	lawnPkg::indexT cursorRow;
	lawnPkg::indexT cursorCol;
	lawnPkg::plantKindE [lawnPkg::lanes-1:0][lawnPkg::columns-1:0] cellKind;
	lawnPkg::indexT [lawnPkg::lanes-1:0] frontCol;
	logic [lawnPkg::lanes-1:0] frontValid;
	lawnPkg::plantKindE [lawnPkg::lanes-1:0] frontKind;
	logic [lawnPkg::lanes-1:0] hasPea;
	logic [lawnPkg::lanes-1:0] eatPulse;
	lawnPkg::coordT [lawnPkg::lanes-1:0] zombieX;
	logic [lawnPkg::lanes-1:0] zombieAlive;

	plantGrid u_plantGrid
	(
		.clk(clk),
		.rstN(rstN),
		.upButton(upButton),
		.downButton(downButton),
		.leftButton(leftButton),
		.rightButton(rightButton),
		.selectButton(selectButton),
		.eatPulse(eatPulse),
		.menuState(menuState),
		.menuCol(menuCol),
		.cursorRow(cursorRow),
		.cursorCol(cursorCol),
		.cellKind(cellKind),
		.frontCol(frontCol),
		.frontValid(frontValid),
		.frontKind(frontKind),
		.hasPea(hasPea)
	);

	zombieHorde
	#(
		.tickDiv(tickDiv),
		.killHits(killHits),
		.eatTicks(eatTicks),
		.walnutEatTicks(walnutEatTicks)
	)
	u_zombieHorde
	(
		.clk(clk),
		.rstN(rstN),
		.frontCol(frontCol),
		.frontValid(frontValid),
		.frontKind(frontKind),
		.hasPea(hasPea),
		.zombieX(zombieX),
		.zombieAlive(zombieAlive),
		.eatPulse(eatPulse),
		.zombiesKilled(zombiesKilled),
		.gameState(gameState)
	);

	lawnRenderer u_lawnRenderer
	(
		.bright(bright),
		.hCount(hCount),
		.vCount(vCount),
		.menuState(menuState),
		.menuCol(menuCol),
		.cursorRow(cursorRow),
		.cursorCol(cursorCol),
		.cellKind(cellKind),
		.zombieX(zombieX),
		.zombieAlive(zombieAlive),
		.rgb(rgb)
	);

endmodule

`default_nettype wire

// ==== hw/lawnRenderer.sv ====
`timescale 1ns/1ns
`default_nettype none

module lawnRenderer
(
	input wire bright,
	input wire lawnPkg::coordT hCount,
	input wire lawnPkg::coordT vCount,
	input wire lawnPkg::menuStateE menuState,
	input wire [1:0] menuCol,
	input wire lawnPkg::indexT cursorRow,
	input wire lawnPkg::indexT cursorCol,
	input wire lawnPkg::plantKindE [lawnPkg::lanes-1:0][lawnPkg::columns-1:0] cellKind,
	input wire lawnPkg::coordT [lawnPkg::lanes-1:0] zombieX,
	input wire [lawnPkg::lanes-1:0] zombieAlive,
	output lawnPkg::rgbT rgb
);

	// Plant markers fill the middle half of a cell
	localparam lawnPkg::coordT quarterW = lawnPkg::columnWidth >> 2;
	localparam lawnPkg::coordT quarterH = lawnPkg::rowHeight >> 2;

	lawnPkg::coordT boxLeft;
	lawnPkg::coordT boxRight;
	lawnPkg::coordT boxTop;
	lawnPkg::coordT boxBottom;
	lawnPkg::coordT cellX;
	lawnPkg::coordT cellY;
	lawnPkg::rgbT plantColour;
	logic onOutline;
	logic onZombie;
	logic onPlant;
	logic oddCell;

	// The red frame follows the menu box or the lawn cursor, depending on the FSM state
	always_comb
	begin
		if (menuState == lawnPkg::pickKind)
		begin
			boxLeft = lawnPkg::coordT'(menuCol) * lawnPkg::menuBoxWidth;
			boxRight = boxLeft + lawnPkg::menuBoxWidth - 10'd1;
			boxTop = '0;
			boxBottom = lawnPkg::menuBottom;
		end
		else
		begin
			boxLeft = lawnPkg::cellLeft(cursorCol);
			boxRight = boxLeft + lawnPkg::columnWidth - 10'd1;
			boxTop = lawnPkg::rowTop(cursorRow);
			boxBottom = boxTop + lawnPkg::rowHeight - 10'd1;
		end
		onOutline = hCount >= boxLeft && hCount <= boxRight &&
			vCount >= boxTop && vCount <= boxBottom &&
			(hCount < boxLeft + lawnPkg::outlineWidth ||
			hCount > boxRight - lawnPkg::outlineWidth ||
			vCount < boxTop + lawnPkg::outlineWidth ||
			vCount > boxBottom - lawnPkg::outlineWidth);
	end

	always_comb
	begin
		onZombie = 1'b0;
		onPlant = 1'b0;
		oddCell = 1'b0;
		plantColour = lawnPkg::black;
		cellX = lawnPkg::lawnLeft;
		cellY = lawnPkg::lawnTop;
		for (int r = 0; r < lawnPkg::lanes; r++)
		begin
			cellY = lawnPkg::rowTop(lawnPkg::indexT'(r));
			if (zombieAlive[r] && hCount >= zombieX[r] - lawnPkg::halfBodyWidth &&
				hCount <= zombieX[r] + lawnPkg::halfBodyWidth &&
				vCount >= cellY && vCount < cellY + lawnPkg::bodyHeight)
				onZombie = 1'b1;
			for (int c = 0; c < lawnPkg::columns; c++)
			begin
				cellX = lawnPkg::cellLeft(lawnPkg::indexT'(c));
				if (hCount >= cellX && hCount < cellX + lawnPkg::columnWidth &&
					vCount >= cellY && vCount < cellY + lawnPkg::rowHeight)
				begin
					oddCell = ((r + c) % 2) == 1;
					if (cellKind[r][c] != lawnPkg::none &&
						hCount >= cellX + quarterW &&
						hCount < cellX + lawnPkg::columnWidth - quarterW &&
						vCount >= cellY + quarterH &&
						vCount < cellY + lawnPkg::rowHeight - quarterH)
					begin
						onPlant = 1'b1;
						case (cellKind[r][c])
							lawnPkg::peashooter: plantColour = lawnPkg::plantPea;
							lawnPkg::sunflower: plantColour = lawnPkg::plantSun;
							default: plantColour = lawnPkg::plantNut;
						endcase
					end
				end
			end
		end
	end

	// First match wins
	always_comb
	begin
		if (!bright)
			rgb = lawnPkg::black;
		else if (onOutline)
			rgb = lawnPkg::red;
		else if (onZombie)
			rgb = lawnPkg::zombieSkin;
		else if (onPlant)
			rgb = plantColour;
		else if (vCount <= lawnPkg::menuBottom)
			rgb = lawnPkg::grey;
		else if (oddCell)
			rgb = lawnPkg::darkGreen;
		else
			rgb = lawnPkg::green;
	end

endmodule

`default_nettype wire

// ==== hw/zombieHorde.sv ====
`timescale 1ns/1ns
`default_nettype none

module zombieHorde
#(
	parameter int tickDiv = 4,
	parameter int killHits = 5,
	parameter int eatTicks = 8,
	parameter int walnutEatTicks = 20
)
(
	input wire clk,
	input wire rstN,
	input wire lawnPkg::indexT [lawnPkg::lanes-1:0] frontCol,
	input wire [lawnPkg::lanes-1:0] frontValid,
	input wire lawnPkg::plantKindE [lawnPkg::lanes-1:0] frontKind,
	input wire [lawnPkg::lanes-1:0] hasPea,
	output lawnPkg::coordT [lawnPkg::lanes-1:0] zombieX,
	output logic [lawnPkg::lanes-1:0] zombieAlive,
	output logic [lawnPkg::lanes-1:0] eatPulse,
	output logic [2:0] zombiesKilled,
	output lawnPkg::gameStateE gameState
);

	localparam int divW = $clog2(tickDiv + 1);
	localparam int hitW = $clog2(killHits + 1);
	localparam int eatMax = (walnutEatTicks > eatTicks) ? walnutEatTicks : eatTicks;
	localparam int eatW = $clog2(eatMax + 1);
	localparam lawnPkg::coordT halfColumn = lawnPkg::columnWidth >> 1;
	// Positions a leading zombie must pass before the next lane may start
	localparam lawnPkg::coordT leadFar = lawnPkg::zombieStartX - (lawnPkg::staggerGap << 1);
	localparam lawnPkg::coordT leadNear = lawnPkg::zombieStartX - lawnPkg::staggerGap;

	logic [divW-1:0] divCount;
	logic tick;
	logic [lawnPkg::lanes-1:0] gateOk;
	logic [lawnPkg::lanes-1:0] stopped;
	logic [lawnPkg::lanes-1:0][eatW-1:0] eatLimit;
	logic [lawnPkg::lanes-1:0][hitW-1:0] hits;
	logic [lawnPkg::lanes-1:0][hitW-1:0] hitsNext;
	logic [lawnPkg::lanes-1:0][eatW-1:0] eatCount;
	logic [lawnPkg::lanes-1:0][eatW-1:0] eatCountNext;
	lawnPkg::coordT [lawnPkg::lanes-1:0] xNext;
	logic [lawnPkg::lanes-1:0] aliveNext;
	logic [lawnPkg::lanes-1:0] eatNext;
	logic [2:0] killedNext;
	lawnPkg::gameStateE stateNext;
	logic reachedEnd;

	assign tick = (divCount == divW'(tickDiv - 1));

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			divCount <= '0;
		else if (tick)
			divCount <= '0;
		else
			divCount <= divCount + 1'b1;
	end

	// Lane 1 leads, the others wait for their leader to walk in
	always_comb
	begin
		gateOk[0] = zombieX[1] <= leadFar;
		gateOk[1] = 1'b1;
		gateOk[2] = zombieX[0] <= leadNear;
		gateOk[3] = zombieX[0] <= leadNear;
		gateOk[4] = zombieX[3] <= leadNear;
		for (int z = 0; z < lawnPkg::lanes; z++)
		begin
			stopped[z] = frontValid[z] &&
				(zombieX[z] == lawnPkg::cellLeft(frontCol[z]) + halfColumn);
			eatLimit[z] = (frontKind[z] == lawnPkg::walnut) ? eatW'(walnutEatTicks) :
				eatW'(eatTicks);
		end
	end

	always_comb
	begin
		xNext = zombieX;
		aliveNext = zombieAlive;
		hitsNext = hits;
		eatCountNext = eatCount;
		eatNext = '0;
		killedNext = zombiesKilled;
		stateNext = gameState;
		reachedEnd = 1'b0;
		if (tick && gameState == lawnPkg::playing)
		begin
			for (int z = 0; z < lawnPkg::lanes; z++)
			begin
				if (zombieAlive[z])
				begin
					if (stopped[z])
					begin
						eatCountNext[z] = eatCount[z] + 1'b1;
						if (eatCountNext[z] == eatLimit[z])
						begin
							eatNext[z] = 1'b1;
							eatCountNext[z] = '0;
						end
					end
					else
					begin
						eatCountNext[z] = '0;
						if (gateOk[z])
							xNext[z] = zombieX[z] - 1'b1;
					end
					// Peashooters only reach zombies that have stepped onto the screen
					if (hasPea[z] && zombieX[z] < lawnPkg::zombieStartX)
					begin
						hitsNext[z] = hits[z] + 1'b1;
						if (hitsNext[z] == hitW'(killHits))
						begin
							aliveNext[z] = 1'b0;
							killedNext = killedNext + 3'd1;
						end
					end
				end
			end
			for (int z = 0; z < lawnPkg::lanes; z++)
				if (aliveNext[z] && xNext[z] == lawnPkg::endOfLawn)
					reachedEnd = 1'b1;
			if (reachedEnd)
				stateNext = lawnPkg::lost;
			else if (killedNext == 3'(lawnPkg::lanes))
				stateNext = lawnPkg::won;
		end
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			zombieX <= {lawnPkg::lanes{lawnPkg::zombieStartX}};
			zombieAlive <= '1;
			hits <= '0;
			eatCount <= '0;
			eatPulse <= '0;
			zombiesKilled <= '0;
			gameState <= lawnPkg::playing;
		end
		else
		begin
			zombieX <= xNext;
			zombieAlive <= aliveNext;
			hits <= hitsNext;
			eatCount <= eatCountNext;
			eatPulse <= eatNext;
			zombiesKilled <= killedNext;
			gameState <= stateNext;
		end
	end

endmodule

`default_nettype wire

// ==== hw/plantGrid.sv ====
`timescale 1ns/1ns
`default_nettype none

module plantGrid
(
	input wire clk,
	input wire rstN,
	input wire upButton,
	input wire downButton,
	input wire leftButton,
	input wire rightButton,
	input wire selectButton,
	input wire [lawnPkg::lanes-1:0] eatPulse,
	output lawnPkg::menuStateE menuState,
	output logic [1:0] menuCol,
	output lawnPkg::indexT cursorRow,
	output lawnPkg::indexT cursorCol,
	output lawnPkg::plantKindE [lawnPkg::lanes-1:0][lawnPkg::columns-1:0] cellKind,
	output lawnPkg::indexT [lawnPkg::lanes-1:0] frontCol,
	output logic [lawnPkg::lanes-1:0] frontValid,
	output lawnPkg::plantKindE [lawnPkg::lanes-1:0] frontKind,
	output logic [lawnPkg::lanes-1:0] hasPea
);

	localparam logic [1:0] lastMenu = 2'd2;
	localparam lawnPkg::indexT lastRow = lawnPkg::indexT'(lawnPkg::lanes - 1);
	localparam lawnPkg::indexT lastCol = lawnPkg::indexT'(lawnPkg::columns - 1);

	lawnPkg::plantKindE chosenKind;

	// One button action per cycle, select wins over the arrows
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			menuState <= lawnPkg::pickKind;
			menuCol <= '0;
			chosenKind <= lawnPkg::none;
			cursorRow <= '0;
			cursorCol <= '0;
			for (int r = 0; r < lawnPkg::lanes; r++)
				for (int c = 0; c < lawnPkg::columns; c++)
					cellKind[r][c] <= lawnPkg::none;
		end
		else
		begin
			if (selectButton)
			begin
				if (menuState == lawnPkg::pickKind)
				begin
					// Menu boxes hold peashooter, sunflower and walnut from left to right
					chosenKind <= lawnPkg::plantKindE'(menuCol + 2'd1);
					menuState <= lawnPkg::pickCell;
				end
				else if (cellKind[cursorRow][cursorCol] == lawnPkg::none)
				begin
					cellKind[cursorRow][cursorCol] <= chosenKind;
					menuState <= lawnPkg::pickKind;
				end
			end
			else if (leftButton)
			begin
				if (menuState == lawnPkg::pickKind)
				begin
					if (menuCol != 2'd0)
						menuCol <= menuCol - 2'd1;
				end
				else if (cursorCol != '0)
					cursorCol <= cursorCol - 3'd1;
			end
			else if (rightButton)
			begin
				if (menuState == lawnPkg::pickKind)
				begin
					if (menuCol != lastMenu)
						menuCol <= menuCol + 2'd1;
				end
				else if (cursorCol != lastCol)
					cursorCol <= cursorCol + 3'd1;
			end
			else if (upButton)
			begin
				if (menuState == lawnPkg::pickCell && cursorRow != '0)
					cursorRow <= cursorRow - 3'd1;
			end
			else if (downButton)
			begin
				if (menuState == lawnPkg::pickCell && cursorRow != lastRow)
					cursorRow <= cursorRow + 3'd1;
			end

			// An eaten plant is always the front one, so it never collides with a placement
			for (int r = 0; r < lawnPkg::lanes; r++)
				if (eatPulse[r])
					cellKind[r][frontCol[r]] <= lawnPkg::none;
		end
	end

	// The last occupied column seen in the scan is the rightmost plant
	always_comb
	begin
		for (int r = 0; r < lawnPkg::lanes; r++)
		begin
			frontCol[r] = '0;
			frontValid[r] = 1'b0;
			frontKind[r] = lawnPkg::none;
			hasPea[r] = 1'b0;
			for (int c = 0; c < lawnPkg::columns; c++)
			begin
				if (cellKind[r][c] != lawnPkg::none)
				begin
					frontCol[r] = lawnPkg::indexT'(c);
					frontValid[r] = 1'b1;
					frontKind[r] = cellKind[r][c];
				end
				if (cellKind[r][c] == lawnPkg::peashooter)
					hasPea[r] = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/lawnPkg.sv ====
`default_nettype none

package lawnPkg;

	localparam int lanes = 5;
	localparam int columns = 5;

	typedef logic [9:0] coordT;
	typedef logic [11:0] rgbT;
	// Row or column number on the lawn grid
	typedef logic [2:0] indexT;

	localparam rgbT black = 12'h000;
	localparam rgbT grey = 12'hAAB;
	localparam rgbT green = 12'h0F0;
	localparam rgbT darkGreen = 12'h392;
	localparam rgbT red = 12'hF00;
	localparam rgbT zombieSkin = 12'h0B4;
	localparam rgbT plantPea = 12'h6F6;
	localparam rgbT plantSun = 12'hFF0;
	localparam rgbT plantNut = 12'hA62;

	// The grey strip covers vCount 0 to menuBottom, the lawn starts right below it
	localparam coordT menuBottom = 10'd86;
	localparam coordT lawnTop = 10'd87;
	localparam coordT rowHeight = 10'd87;
	localparam coordT lawnLeft = 10'd300;
	localparam coordT columnWidth = 10'd100;
	localparam coordT menuBoxWidth = 10'd80;
	localparam coordT zombieStartX = 10'd799;
	localparam coordT endOfLawn = 10'd124;
	localparam coordT staggerGap = 10'd100;
	localparam coordT halfBodyWidth = 10'd8;
	localparam coordT bodyHeight = 10'd50;
	localparam coordT outlineWidth = 10'd2;

	typedef enum logic [1:0] {none, peashooter, sunflower, walnut} plantKindE;
	typedef enum logic {pickKind, pickCell} menuStateE;
	typedef enum logic [1:0] {playing, won, lost} gameStateE;

	function automatic coordT cellLeft(input indexT col);
		return lawnLeft + coordT'(col) * columnWidth;
	endfunction

	function automatic coordT rowTop(input indexT row);
		return lawnTop + coordT'(row) * rowHeight;
	endfunction

endpackage

`default_nettype wire
